/* rv_pkg.sv */
`default_nettype none

package rv_pkg;

    // major opcodes of the base integer set that the core executes
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_t;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_DECODE,
        ST_EXEC,
        ST_MEM,
        ST_WRITE
    } core_state_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {
        RES_ALU,
        RES_LOAD,
        RES_PC4
    } res_src_t;

    typedef struct packed {
        logic [31:0] adr;
        logic [31:0] dat;
        logic        we;
        logic [3:0]  sel;
        logic        stb;
        logic        cyc;
    } wb_req_t;

    typedef struct packed {
        logic [31:0] dat;
        logic        ack;
    } wb_rsp_t;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
    } fetch_bus_t;

    typedef struct packed {
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] imm;
        alu_op_t     alu_op;
        res_src_t    res_src;
        logic [2:0]  funct3;
        logic        a_is_pc;
        logic        b_is_imm;
        logic        reg_write;
        logic        is_load;
        logic        is_store;
        logic        is_branch;
        logic        is_jal;
        logic        is_jalr;
    } decode_bus_t;

    typedef struct packed {
        logic [31:0] result;
        logic        taken;
        logic [31:0] target;
    } alu_bus_t;

endpackage

`default_nettype wire

/* rv_fetch.sv */
`default_nettype none

module rv_fetch
    import rv_pkg::*;
#(
    parameter logic [31:0] RESET_ADDR = 32'h0000_0000
)
(
    input  wire         i_clk,
    input  wire         i_reset_n,
    input  wire         i_load_instr,
    input  wire  [31:0] i_instr,
    input  wire         i_advance,
    input  wire         i_taken,
    input  wire  [31:0] i_target,
    output logic [31:0] o_pc,
    output fetch_bus_t  o_bus
);

    logic [31:0] pc;
    logic [31:0] instr_q;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            pc <= RESET_ADDR;
        else if (i_advance)
            pc <= i_taken ? i_target : pc + 32'd4;
    end

    // the instruction register is loaded on the fetch acknowledge
    always_ff @(posedge i_clk)
    begin
        if (i_load_instr)
            instr_q <= i_instr;
    end

    assign o_pc = pc;
    assign o_bus.instr = instr_q;
    assign o_bus.pc = pc;

    // misaligned targets are not supported, so every jump must land on a word
    a_pc_aligned: assert property (
        @(posedge i_clk) disable iff (!i_reset_n)
        i_advance |=> (pc[1:0] == 2'b00)
    );

endmodule

`default_nettype wire

/* rv_decode.sv */
`default_nettype none

module rv_decode
    import rv_pkg::*;
(
    input  wire fetch_bus_t  i_bus,
    output decode_bus_t      o_bus
);

    logic [31:0] instr;
    opcode_t     opcode;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic        alt;
    alu_op_t     f3_op;

    assign instr = i_bus.instr;
    assign opcode = opcode_t'(instr[6:0]);

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'h000};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // funct7 bit 5 selects sub and sra; OP-IMM has no subtract form
    assign alt = instr[30];

    always_comb
    begin
        case (instr[14:12])
            3'b000:  f3_op = (alt && opcode == OPC_OP) ? ALU_SUB : ALU_ADD;
            3'b001:  f3_op = ALU_SLL;
            3'b010:  f3_op = ALU_SLT;
            3'b011:  f3_op = ALU_SLTU;
            3'b100:  f3_op = ALU_XOR;
            3'b101:  f3_op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  f3_op = ALU_OR;
            default: f3_op = ALU_AND;
        endcase
    end

    always_comb
    begin
        o_bus = '0;
        o_bus.rs1 = instr[19:15];
        o_bus.rs2 = instr[24:20];
        o_bus.rd = instr[11:7];
        o_bus.funct3 = instr[14:12];
        o_bus.imm = imm_i;
        o_bus.alu_op = ALU_ADD;
        o_bus.res_src = RES_ALU;
        case (opcode)
            OPC_LUI:
            begin
                o_bus.imm = imm_u;
                o_bus.alu_op = ALU_PASS_B;
                o_bus.b_is_imm = 1'b1;
                o_bus.reg_write = 1'b1;
            end
            OPC_AUIPC:
            begin
                o_bus.imm = imm_u;
                o_bus.a_is_pc = 1'b1;
                o_bus.b_is_imm = 1'b1;
                o_bus.reg_write = 1'b1;
            end
            OPC_JAL:
            begin
                o_bus.imm = imm_j;
                o_bus.res_src = RES_PC4;
                o_bus.reg_write = 1'b1;
                o_bus.is_jal = 1'b1;
            end
            OPC_JALR:
            begin
                o_bus.res_src = RES_PC4;
                o_bus.reg_write = 1'b1;
                o_bus.is_jalr = 1'b1;
            end
            OPC_BRANCH:
            begin
                // the adder subtracts rs2 from rs1 to give the compare flags
                o_bus.imm = imm_b;
                o_bus.alu_op = ALU_SUB;
                o_bus.is_branch = 1'b1;
            end
            OPC_LOAD:
            begin
                o_bus.b_is_imm = 1'b1;
                o_bus.res_src = RES_LOAD;
                o_bus.reg_write = 1'b1;
                o_bus.is_load = 1'b1;
            end
            OPC_STORE:
            begin
                o_bus.imm = imm_s;
                o_bus.b_is_imm = 1'b1;
                o_bus.is_store = 1'b1;
            end
            OPC_OP_IMM:
            begin
                o_bus.alu_op = f3_op;
                o_bus.b_is_imm = 1'b1;
                o_bus.reg_write = 1'b1;
            end
            OPC_OP:
            begin
                o_bus.alu_op = f3_op;
                o_bus.reg_write = 1'b1;
            end
            default:
            begin
                o_bus.reg_write = 1'b0;
                o_bus.is_load = 1'b0;
                o_bus.is_store = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rv_regs.sv */
`default_nettype none

module rv_regs
(
    input  wire         i_clk,
    input  wire         i_reset_n,
    input  wire  [4:0]  i_rs1,
    input  wire  [4:0]  i_rs2,
    input  wire  [4:0]  i_rd,
    input  wire         i_write,
    input  wire  [31:0] i_data,
    output logic [31:0] o_data1,
    output logic [31:0] o_data2
);

    // x0 has no storage
    logic [31:0] regs [1:31];

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (i_write && i_rd != 5'd0)
            regs[i_rd] <= i_data;
    end

    always_ff @(posedge i_clk)
    begin
        o_data1 <= (i_rs1 == 5'd0) ? '0 : regs[i_rs1];
        o_data2 <= (i_rs2 == 5'd0) ? '0 : regs[i_rs2];
    end

endmodule

`default_nettype wire

/* rv_alu.sv */
`default_nettype none

module rv_alu
    import rv_pkg::*;
(
    input  wire              i_clk,
    input  wire decode_bus_t i_dec,
    input  wire  [31:0]      i_pc,
    input  wire  [31:0]      i_rs1_data,
    input  wire  [31:0]      i_rs2_data,
    output alu_bus_t         o_bus
);

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic        use_sub;
    logic [32:0] sum;
    logic        overflow;
    logic        eq;
    logic        lts;
    logic        ltu;
    logic        cond;
    logic [31:0] result;
    logic [31:0] jalr_target;
    logic [31:0] target;

    assign op_a = i_dec.a_is_pc ? i_pc : i_rs1_data;
    assign op_b = i_dec.b_is_imm ? i_dec.imm : i_rs2_data;

    // one adder serves add, sub and both compares
    assign use_sub = (i_dec.alu_op == ALU_SUB) || (i_dec.alu_op == ALU_SLT) ||
                     (i_dec.alu_op == ALU_SLTU);
    assign sum = {1'b0, op_a} + {1'b0, use_sub ? ~op_b : op_b} + {32'd0, use_sub};
    assign overflow = (op_a[31] ^ op_b[31]) & (op_a[31] ^ sum[31]);

    assign eq = (op_a == op_b);
    assign lts = sum[31] ^ overflow;
    assign ltu = ~sum[32];

    // funct3 bit 2 picks a less-than test, bit 1 unsigned, bit 0 inverts
    assign cond = (i_dec.funct3[2] ? (i_dec.funct3[1] ? ltu : lts) : eq) ^ i_dec.funct3[0];

    always_comb
    begin
        case (i_dec.alu_op)
            ALU_ADD,
            ALU_SUB:    result = sum[31:0];
            ALU_SLL:    result = op_a << op_b[4:0];
            ALU_SLT:    result = {31'd0, lts};
            ALU_SLTU:   result = {31'd0, ltu};
            ALU_XOR:    result = op_a ^ op_b;
            ALU_SRL:    result = op_a >> op_b[4:0];
            ALU_SRA:    result = $unsigned($signed(op_a) >>> op_b[4:0]);
            ALU_OR:     result = op_a | op_b;
            ALU_AND:    result = op_a & op_b;
            ALU_PASS_B: result = op_b;
            default:    result = sum[31:0];
        endcase
    end

    assign jalr_target = i_rs1_data + i_dec.imm;
    assign target = i_dec.is_jalr ? {jalr_target[31:1], 1'b0} : i_pc + i_dec.imm;

    always_ff @(posedge i_clk)
    begin
        o_bus.result <= result;
        o_bus.taken <= i_dec.is_jal | i_dec.is_jalr | (i_dec.is_branch & cond);
        o_bus.target <= target;
    end

endmodule

`default_nettype wire

/* rv_lsu.sv */
`default_nettype none

module rv_lsu
(
    input  wire  [2:0]  i_funct3,
    input  wire  [1:0]  i_addr_lo,
    input  wire  [31:0] i_store_data,
    input  wire  [31:0] i_rdata,
    output logic [3:0]  o_sel,
    output logic [31:0] o_wdata,
    output logic [31:0] o_load_data
);

    logic [7:0]  lane_byte;
    logic [15:0] lane_half;

    // stores put the value on every lane and let the select pick the bytes
    always_comb
    begin
        case (i_funct3[1:0])
            2'b00:
            begin
                o_wdata = {4{i_store_data[7:0]}};
                o_sel = 4'b0001 << i_addr_lo;
            end
            2'b01:
            begin
                o_wdata = {2{i_store_data[15:0]}};
                o_sel = i_addr_lo[1] ? 4'b1100 : 4'b0011;
            end
            default:
            begin
                o_wdata = i_store_data;
                o_sel = 4'b1111;
            end
        endcase
    end

    always_comb
    begin
        case (i_addr_lo)
            2'b00:   lane_byte = i_rdata[7:0];
            2'b01:   lane_byte = i_rdata[15:8];
            2'b10:   lane_byte = i_rdata[23:16];
            default: lane_byte = i_rdata[31:24];
        endcase
    end

    assign lane_half = i_addr_lo[1] ? i_rdata[31:16] : i_rdata[15:0];

    always_comb
    begin
        case (i_funct3)
            3'b000:  o_load_data = {{24{lane_byte[7]}}, lane_byte};
            3'b001:  o_load_data = {{16{lane_half[15]}}, lane_half};
            3'b100:  o_load_data = {24'd0, lane_byte};
            3'b101:  o_load_data = {16'd0, lane_half};
            default: o_load_data = i_rdata;
        endcase
    end

endmodule

`default_nettype wire

/* rv_core.sv */
`default_nettype none

module rv_core
    import rv_pkg::*;
#(
    parameter logic [31:0] RESET_ADDR = 32'h0000_0000
)
(
    input  wire          i_clk,
    input  wire          i_reset_n,
    input  wire wb_rsp_t i_wb_rsp,
    output wb_req_t      o_wb_req
);

    core_state_t state;
    core_state_t state_nxt;
    logic        stb_q;
    logic        xfer;
    fetch_bus_t  fetch_bus;
    decode_bus_t dec;
    alu_bus_t    alu;
    logic [31:0] pc;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] wb_data;
    logic [31:0] load_data;
    logic [31:0] load_q;
    logic [31:0] store_data;
    logic [3:0]  store_sel;

    assign xfer = stb_q & i_wb_rsp.ack;

    always_comb
    begin
        case (state)
            ST_FETCH:  state_nxt = xfer ? ST_DECODE : ST_FETCH;
            ST_DECODE: state_nxt = ST_EXEC;
            ST_EXEC:   state_nxt = (dec.is_load | dec.is_store) ? ST_MEM : ST_WRITE;
            ST_MEM:    state_nxt = xfer ? ST_WRITE : ST_MEM;
            default:   state_nxt = ST_FETCH;
        endcase
    end

    // the strobe is a flop so that it drops in the cycle after the ack
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            state <= ST_FETCH;
            stb_q <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            stb_q <= (state_nxt == ST_FETCH) || (state_nxt == ST_MEM);
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (state == ST_MEM && xfer)
            load_q <= load_data;
    end

    always_comb
    begin
        case (dec.res_src)
            RES_LOAD: wb_data = load_q;
            RES_PC4:  wb_data = fetch_bus.pc + 32'd4;
            default:  wb_data = alu.result;
        endcase
    end

    always_comb
    begin
        o_wb_req.adr = (state == ST_MEM) ? alu.result : pc;
        o_wb_req.dat = (state == ST_MEM) ? store_data : '0;
        o_wb_req.we = stb_q & (state == ST_MEM) & dec.is_store;
        o_wb_req.sel = (state == ST_MEM) ? store_sel : 4'b1111;
        o_wb_req.stb = stb_q;
        o_wb_req.cyc = stb_q;
    end

    rv_fetch #(
        .RESET_ADDR   (RESET_ADDR)
    ) u_fetch (
        .i_clk        (i_clk),
        .i_reset_n    (i_reset_n),
        .i_load_instr ((state == ST_FETCH) && xfer),
        .i_instr      (i_wb_rsp.dat),
        .i_advance    (state == ST_WRITE),
        .i_taken      (alu.taken),
        .i_target     (alu.target),
        .o_pc         (pc),
        .o_bus        (fetch_bus)
    );

    rv_decode u_decode (
        .i_bus        (fetch_bus),
        .o_bus        (dec)
    );

    rv_regs u_regs (
        .i_clk        (i_clk),
        .i_reset_n    (i_reset_n),
        .i_rs1        (dec.rs1),
        .i_rs2        (dec.rs2),
        .i_rd         (dec.rd),
        .i_write      ((state == ST_WRITE) && dec.reg_write),
        .i_data       (wb_data),
        .o_data1      (rs1_data),
        .o_data2      (rs2_data)
    );

    rv_alu u_alu (
        .i_clk        (i_clk),
        .i_dec        (dec),
        .i_pc         (fetch_bus.pc),
        .i_rs1_data   (rs1_data),
        .i_rs2_data   (rs2_data),
        .o_bus        (alu)
    );

    rv_lsu u_lsu (
        .i_funct3     (dec.funct3),
        .i_addr_lo    (alu.result[1:0]),
        .i_store_data (rs2_data),
        .i_rdata      (i_wb_rsp.dat),
        .o_sel        (store_sel),
        .o_wdata      (store_data),
        .o_load_data  (load_data)
    );

    a_req_stable: assert property (
        @(posedge i_clk) disable iff (!i_reset_n)
        (o_wb_req.stb && !i_wb_rsp.ack) |=>
            (o_wb_req.stb && $stable(o_wb_req.adr) && $stable(o_wb_req.dat) &&
             $stable(o_wb_req.we) && $stable(o_wb_req.sel))
    );

    // halfword and word data accesses must be naturally aligned
    a_mem_aligned: assert property (
        @(posedge i_clk) disable iff (!i_reset_n)
        (o_wb_req.stb && state == ST_MEM) |->
            ((dec.funct3[1:0] == 2'b00) ||
             (dec.funct3[1:0] == 2'b01 && !o_wb_req.adr[0]) ||
             (o_wb_req.adr[1:0] == 2'b00))
    );

endmodule

`default_nettype wire

/* tb_mem.sv */
`default_nettype none

module tb_mem
    import rv_pkg::*;
#(
    parameter int WORDS = 4096
)
(
    input  wire          i_clk,
    input  wire wb_req_t i_req,
    output wb_rsp_t      o_rsp
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] mem [0:WORDS-1];
    logic [11:0] idx;
    int unsigned wait_left;

    assign idx = i_req.adr[13:2];

    initial
    begin
        // every word differs, so a wrong address shows up as wrong data
        for (int i = 0; i < WORDS; i++)
            mem[i] = (i * 32'h9e37_79b9) ^ {i[15:0], ~i[15:0]};
        o_rsp = '0;
        wait_left = 0;
    end

    // ack goes high for one cycle after 0 to 3 extra wait cycles
    always @(posedge i_clk)
    begin
        #1;
        if (o_rsp.ack)
            o_rsp.ack = 1'b0;
        else if (i_req.stb && i_req.cyc)
        begin
            if (wait_left == 0)
            begin
                if (i_req.we)
                begin
                    for (int b = 0; b < 4; b++)
                        if (i_req.sel[b])
                            mem[idx][8*b +: 8] = i_req.dat[8*b +: 8];
                end
                o_rsp.dat = mem[idx];
                o_rsp.ack = 1'b1;
                wait_left = $urandom_range(3, 0);
            end
            else
                wait_left--;
        end
    end

endmodule

`default_nettype wire

/* tb_rv_core.sv */
`default_nettype none

module tb_rv_core
    import rv_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] RESET_ADDR = 32'h0000_0100;
    localparam logic [31:0] RES_BASE = 32'h0000_0800;
    localparam logic [31:0] DATA_BASE = 32'h0000_0c00;

    logic        clk;
    logic        rst_n;
    wb_req_t     req;
    wb_rsp_t     rsp;
    logic [31:0] rf [0:31];
    logic [31:0] fetch_exp [0:1023];
    logic [31:0] exp_adr [0:511];
    logic [3:0]  exp_sel [0:511];
    logic [31:0] exp_dat [0:511];
    int          n_fetch;
    int          n_store;
    int          f_idx;
    int          st_idx;
    logic [31:0] pc_b;
    logic [11:0] off;
    logic        seen_req;
    int          cycles;
    int          limit;
    int          store_errs;
    int          fetch_errs;
    int          bus_errs;
    logic        st_fire;
    logic        f_fire;

    rv_core #(.RESET_ADDR(RESET_ADDR)) rv_core_i (
        .i_clk    (clk),
        .i_reset_n(rst_n),
        .i_wb_rsp (rsp),
        .o_wb_req (req)
    );

    tb_mem mem_i (
        .i_clk(clk),
        .i_req(req),
        .o_rsp(rsp)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << sh;
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return alt ? 32'($signed(a) >>> sh) : a >> sh;
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    task automatic emit(input logic [31:0] instr);
        mem_i.mem[pc_b[13:2]] = instr;
        fetch_exp[n_fetch] = pc_b;
        n_fetch++;
        pc_b += 4;
    endtask

    // written into memory but skipped by the control flow
    task automatic place(input logic [31:0] instr);
        mem_i.mem[pc_b[13:2]] = instr;
        pc_b += 4;
    endtask

    task automatic expect_store(input logic [31:0] adr, input logic [3:0] sel,
                                input logic [31:0] dat);
        exp_adr[n_store] = adr;
        exp_sel[n_store] = sel;
        exp_dat[n_store] = dat;
        n_store++;
    endtask

    task automatic set_reg(input logic [4:0] rd, input logic [31:0] val);
        logic [31:0] upper;
        upper = val + 32'h800;
        emit({upper[31:12], rd, OPC_LUI});
        emit(enc_i(val[11:0], rd, 3'd0, rd, OPC_OP_IMM));
        rf[rd] = val;
    endtask

    task automatic store_word(input logic [4:0] rs);
        emit(enc_s(off, rs, 5'd31, 3'd2));
        expect_store(RES_BASE + off, 4'hf, rf[rs]);
        off += 4;
    endtask

    task automatic op_reg(input logic [2:0] f3, input logic alt);
        emit({1'b0, alt, 5'd0, 5'd2, 5'd1, f3, 5'd3, OPC_OP});
        rf[3] = alu_ref(f3, alt, rf[1], rf[2]);
        store_word(3);
    endtask

    task automatic op_imm(input logic [2:0] f3, input logic alt, input logic [11:0] imm);
        emit(enc_i(imm, 5'd1, f3, 5'd3, OPC_OP_IMM));
        rf[3] = alu_ref(f3, alt, rf[1], {{20{imm[11]}}, imm});
        store_word(3);
    endtask

    task automatic load_back(input logic [2:0] f3, input logic [11:0] lo);
        logic [31:0] w;
        logic [7:0]  by;
        logic [15:0] hw;
        w = mem_i.mem[(DATA_BASE[13:2]) + lo[11:2]];
        by = w[8*lo[1:0] +: 8];
        hw = w[16*lo[1] +: 16];
        emit(enc_i(lo, 5'd30, f3, 5'd4, OPC_LOAD));
        case (f3)
            3'd0: rf[4] = {{24{by[7]}}, by};
            3'd1: rf[4] = {{16{hw[15]}}, hw};
            3'd4: rf[4] = {24'd0, by};
            3'd5: rf[4] = {16'd0, hw};
            default: rf[4] = w;
        endcase
        store_word(4);
    endtask

    // a taken branch skips the marker store right behind it
    task automatic branch(input logic [2:0] f3, input logic [31:0] a, input logic [31:0] b);
        logic [12:0] imm;
        set_reg(1, a);
        set_reg(2, b);
        imm = 13'd8;
        emit({imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], OPC_BRANCH});
        if (branch_ref(f3, a, b))
            place(enc_s(off, 5'd5, 5'd31, 3'd2));
        else
            store_word(5);
    endtask

    task automatic build_program();
        logic [31:0] a;
        logic [31:0] b;
        logic [19:0] u;
        pc_b = RESET_ADDR;
        off = '0;
        for (int i = 0; i < 32; i++)
            rf[i] = '0;
        for (int i = 0; i < 4; i++)
            mem_i.mem[DATA_BASE[13:2] + i] = $urandom;
        set_reg(31, RES_BASE);
        set_reg(30, DATA_BASE);
        set_reg(5, $urandom);
        for (int r = 0; r < 2; r++)
        begin
            set_reg(1, $urandom);
            set_reg(2, $urandom);
            for (int k = 0; k < 10; k++)
                op_reg((k < 2) ? 3'd0 : (k < 7) ? 3'(k - 1) : 3'(k - 2), k == 1 || k == 7);
        end
        for (int f = 0; f < 8; f++)
            op_imm(3'(f), 1'b0, (f == 1 || f == 5) ? 12'($urandom_range(31, 0)) : 12'($urandom));
        op_imm(3'd5, 1'b1, 12'h400 | 12'($urandom_range(31, 0)));
        op_imm(3'd0, 1'b0, 12'h800);
        u = $urandom;
        emit({u, 5'd3, OPC_LUI});
        rf[3] = {u, 12'h000};
        store_word(3);
        rf[3] = pc_b + {u, 12'h000};
        emit({u, 5'd3, OPC_AUIPC});
        store_word(3);
        for (int k = 0; k < 4; k++)
        begin
            emit(enc_s(off + 12'(k), 5'd1, 5'd31, 3'd0));
            expect_store(RES_BASE + off + k, 4'b0001 << k, {4{rf[1][7:0]}});
        end
        emit(enc_s(off, 5'd1, 5'd31, 3'd1));
        expect_store(RES_BASE + off, 4'b0011, {2{rf[1][15:0]}});
        emit(enc_s(off + 12'd2, 5'd1, 5'd31, 3'd1));
        expect_store(RES_BASE + off + 2, 4'b1100, {2{rf[1][15:0]}});
        off += 4;
        for (int k = 0; k < 4; k++)
        begin
            load_back(3'd0, 12'(k));
            load_back(3'd4, 12'(k));
        end
        for (int k = 0; k < 2; k++)
        begin
            load_back(3'd1, 12'd4 + 12'(2 * k));
            load_back(3'd5, 12'd4 + 12'(2 * k));
        end
        load_back(3'd2, 12'd8);
        for (int f = 0; f < 8; f++)
        begin
            if (f != 2 && f != 3)
            begin
                a = $urandom;
                b = $urandom;
                branch(3'(f), a, b);
                branch(3'(f), b, a);
                branch(3'(f), a, a);
            end
        end
        rf[6] = pc_b + 4;
        emit({1'b0, 10'd4, 1'b0, 8'd0, 5'd6, OPC_JAL});
        place(enc_s(off, 5'd5, 5'd31, 3'd2));
        store_word(6);
        // bit 0 of the jalr sum is odd here and must be cleared
        set_reg(7, pc_b + 12);
        rf[8] = pc_b + 4;
        emit(enc_i(12'd5, 5'd7, 3'd0, 5'd8, OPC_JALR));
        place(enc_s(off, 5'd5, 5'd31, 3'd2));
        store_word(8);
        emit({1'b0, 10'd0, 1'b0, 8'd0, 5'd0, OPC_JAL});
    endtask

    assign st_fire = req.stb & rsp.ack & req.we;
    assign f_fire = req.stb & rsp.ack & ~req.we & (req.adr < RES_BASE);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            seen_req <= 1'b0;
            st_idx <= 0;
            f_idx <= 0;
        end
        else
        begin
            if (req.stb)
                seen_req <= 1'b1;
            if (st_fire)
                st_idx <= st_idx + 1;
            if (f_fire)
                f_idx <= f_idx + 1;
        end
    end

    reset_quiet: assert property (@(posedge clk) !rst_n |-> (!req.stb && !req.cyc))
    else
    begin
        bus_errs++;
        $display("strobe or cycle was high during reset");
    end

    first_adr: assert property (@(posedge clk) disable iff (!rst_n)
        (req.stb && !seen_req) |-> req.adr == RESET_ADDR)
    else
    begin
        bus_errs++;
        $display("Error %0t o_wb_req.adr expected %h got %h",
                 $time, RESET_ADDR, $sampled(req.adr));
    end

    first_kind: assert property (@(posedge clk) disable iff (!rst_n)
        (req.stb && !seen_req) |-> (!req.we && req.sel == 4'hf))
    else
    begin
        bus_errs++;
        $display("first request after reset was not a word read");
    end

    req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (req.stb && !rsp.ack) |=> (req.stb && $stable(req.adr) && $stable(req.dat) &&
                                   $stable(req.we) && $stable(req.sel)))
    else
    begin
        bus_errs++;
        $display("request changed while waiting for ack");
    end

    store_extra: assert property (@(posedge clk) disable iff (!rst_n)
        st_fire |-> st_idx < n_store)
    else
    begin
        store_errs++;
        $display("store issued beyond the expected list");
    end

    store_adr: assert property (@(posedge clk) disable iff (!rst_n)
        (st_fire && st_idx < n_store) |-> req.adr == exp_adr[st_idx])
    else
    begin
        store_errs++;
        $display("Error %0t o_wb_req.adr expected %h got %h",
                 $time, exp_adr[$sampled(st_idx)], $sampled(req.adr));
    end

    store_sel: assert property (@(posedge clk) disable iff (!rst_n)
        (st_fire && st_idx < n_store) |-> req.sel == exp_sel[st_idx])
    else
    begin
        store_errs++;
        $display("Error %0t o_wb_req.sel expected %h got %h",
                 $time, exp_sel[$sampled(st_idx)], $sampled(req.sel));
    end

    store_dat: assert property (@(posedge clk) disable iff (!rst_n)
        (st_fire && st_idx < n_store) |-> req.dat == exp_dat[st_idx])
    else
    begin
        store_errs++;
        $display("Error %0t o_wb_req.dat expected %h got %h",
                 $time, exp_dat[$sampled(st_idx)], $sampled(req.dat));
    end

    fetch_adr: assert property (@(posedge clk) disable iff (!rst_n)
        (f_fire && f_idx < n_fetch) |-> req.adr == fetch_exp[f_idx])
    else
    begin
        fetch_errs++;
        $display("Error %0t o_wb_req.adr expected %h got %h",
                 $time, fetch_exp[$sampled(f_idx)], $sampled(req.adr));
    end

    always @(posedge clk)
    begin
        cycles++;
        if (limit != 0 && cycles > limit)
        begin
            $display("timeout after %0d cycles, %0d of %0d fetches seen", cycles, f_idx,
                     n_fetch);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial
    begin
        rst_n = 1'b0;
        n_fetch = 0;
        n_store = 0;
        cycles = 0;
        limit = 0;
        store_errs = 0;
        fetch_errs = 0;
        bus_errs = 0;
        void'($urandom(32'h002e8fa5));
        #1;
        build_program();
        limit = n_fetch * 20 + 50;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        while (f_idx < n_fetch)
            @(posedge clk);
        repeat (10) @(posedge clk);
        if (st_idx != n_store)
        begin
            store_errs++;
            $display("saw %0d stores but expected %0d", st_idx, n_store);
        end
        $display("errors: store %0d, fetch %0d, bus %0d", store_errs, fetch_errs, bus_errs);
        if (store_errs + fetch_errs + bus_errs == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
rv_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_regs.sv
rv_alu.sv
rv_lsu.sv
rv_core.sv
tb_mem.sv
tb_rv_core.sv

/* run.sh */
#!/bin/bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_core -f sources.f \
    -o tb_rv_core_sim > build.log 2>&1 \
    && ./obj_dir/tb_rv_core_sim > sim.log 2>&1 \
    || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "RESULT: FAIL" sim.log \
    && { echo "simulation failed, see sim.log"; exit 1; } \
    || { echo "simulation passed"; exit 0; }
